//--- all.f
+incdir+verification
design/net_tx_pkg.sv
design/ip_header_gen.sv
design/udp_header_gen.sv
design/frame_serializer.sv
design/net_tx_top.sv
verification/net_tx_tb.sv

//--- design/frame_serializer.sv
/* frame_serializer
   captures a udp send request, starts both header builders and streams
   mac header, ip header, udp header and payload under credit flow control */

`timescale 1ns/1ps

module frame_serializer
  import net_tx_pkg::*;
(
  input  logic         tx_clock,
  input  logic         reset,
  input  logic         udp_tx_request,
  input  logic [15:0]  udp_tx_length,
  input  logic [7:0]   udp_tx_data,
  input  logic [47:0]  local_mac,
  input  logic [47:0]  destination_mac,
  input  logic [31:0]  local_ip,
  input  logic [31:0]  destination_ip,
  input  logic [15:0]  destination_port,
  input  logic         tx_credit,              // one byte of downstream space
  input  logic [159:0] ip_header,
  input  logic         ip_done,
  input  logic [63:0]  udp_header,
  input  logic         udp_done,
  output logic         build_start,
  output logic [15:0]  payload_length,
  output logic [31:0]  captured_local_ip,
  output logic [31:0]  captured_destination_ip,
  output logic [15:0]  captured_destination_port,
  output logic [7:0]   tx_data,
  output logic         tx_valid,
  output logic         udp_tx_enable,
  output logic         tx_active
);

  localparam int HDR_BITS = 8 * FRAME_HDR_BYTES;

  logic [47:0]             captured_destination_mac;
  logic [47:0]             captured_local_mac;
  logic [15:0]             byte_index;   // position in the frame
  logic [CREDIT_WIDTH-1:0] credit_count;
  logic                    capture;
  logic                    headers_ready;
  logic                    credit_add;
  logic                    last_byte;
  logic                    in_header;
  logic [HDR_BITS-1:0]     frame_header;
  logic [HDR_BITS-1:0]     header_shifted;

  assign capture = udp_tx_request && !tx_active;

  // --------------------------------------------------
  // request capture
  // --------------------------------------------------
  always_ff @(posedge tx_clock) begin
    if (capture) begin
      payload_length            <= udp_tx_length;
      captured_destination_mac  <= destination_mac;
      captured_local_mac        <= local_mac;
      captured_local_ip         <= local_ip;
      captured_destination_ip   <= destination_ip;
      captured_destination_port <= destination_port;
    end
  end

  // done levels from the last frame are stale while build_start is up
  assign headers_ready = tx_active && !build_start && ip_done && udp_done;
  assign tx_valid      = headers_ready && (credit_count != '0);
  assign in_header     = byte_index < 16'(FRAME_HDR_BYTES);
  assign udp_tx_enable = tx_valid && !in_header;
  assign last_byte     = byte_index == payload_length + 16'(FRAME_HDR_BYTES - 1);

  // frame control
  always_ff @(posedge tx_clock) begin
    if (reset) begin
      tx_active   <= 1'b0;
      build_start <= 1'b0;
      byte_index  <= 16'd0;
    end else begin
      build_start <= 1'b0;                  // single pulse
      if (capture) begin
        tx_active   <= 1'b1;
        build_start <= 1'b1;
        byte_index  <= 16'd0;
      end else if (tx_valid) begin
        byte_index <= byte_index + 16'd1;
        if (last_byte) begin
          tx_active <= 1'b0;                // low from the next cycle
        end
      end
    end
  end

  // --------------------------------------------------
  // credit counter
  // --------------------------------------------------
  // a pulse at the ceiling only counts when a byte leaves the same cycle
  assign credit_add = tx_credit && (tx_valid || credit_count != CREDIT_WIDTH'(CREDIT_MAX));

  always_ff @(posedge tx_clock) begin
    if (reset) begin
      credit_count <= '0;
    end else if (credit_add && !tx_valid) begin
      credit_count <= credit_count + 1'b1;
    end else if (!credit_add && tx_valid) begin
      credit_count <= credit_count - 1'b1;
    end
  end

  // --------------------------------------------------
  // byte select
  // --------------------------------------------------
  // 42 header bytes as one vector, first byte on the wire at the top
  assign frame_header = {captured_destination_mac, captured_local_mac, ETHERTYPE_IPV4,
                         ip_header, udp_header};
  assign header_shifted = frame_header << {byte_index[5:0], 3'b000};

  // payload passes straight through from the source
  assign tx_data = in_header ? header_shifted[HDR_BITS-1 -: 8] : udp_tx_data;

  a_credit_ceiling : assert property (@(posedge tx_clock) disable iff (reset)
    credit_count <= CREDIT_WIDTH'(CREDIT_MAX));

  a_send_with_credit : assert property (@(posedge tx_clock) disable iff (reset)
    tx_valid |-> credit_count != '0);

  // both builders finished for this frame, never on done levels left from the last one
  a_headers_built : assert property (@(posedge tx_clock) disable iff (reset)
    tx_valid |-> ip_done && udp_done && $past(tx_active));

endmodule

//--- design/ip_header_gen.sv
/* ip_header_gen
   builds the 20-byte ipv4 header with identification counter and
   ones' complement header checksum, one word summed per cycle */

`timescale 1ns/1ps

module ip_header_gen
  import net_tx_pkg::*;
(
  input  logic         tx_clock,
  input  logic         reset,
  input  logic         build_start,     // one cycle pulse per frame
  input  logic [15:0]  payload_length,
  input  logic [31:0]  local_ip,
  input  logic [31:0]  destination_ip,
  output logic [159:0] ip_header,       // word 0 in the top bits
  output logic         done
);

  ip_word_t    hdr_word [IP_HDR_WORDS];
  logic [19:0] csum_acc;   // ten halves cannot overflow 20 bits
  logic [2:0]  phase;      // 0..4 summing, 5 fold
  logic        busy;
  logic [15:0] ident;      // identification of the next frame
  logic [16:0] fold_once;
  logic [15:0] fold_twice;
  logic        summing;

  // --------------------------------------------------
  // end-around carry
  // --------------------------------------------------
  assign fold_once  = {1'b0, csum_acc[15:0]} + {13'd0, csum_acc[19:16]};
  assign fold_twice = fold_once[15:0] + {15'd0, fold_once[16]}; // last carry, no overflow

  assign summing = busy && (phase < 3'(IP_HDR_WORDS));

  // control: 1 form + 5 sum + 1 fold cycles
  always_ff @(posedge tx_clock) begin
    if (reset) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      phase <= 3'd0;
      ident <= 16'd0;
    end else if (build_start) begin
      busy  <= 1'b1;
      done  <= 1'b0;          // header invalid until checksum lands
      phase <= 3'd0;
      ident <= ident + 16'd1; // once per frame
    end else if (busy) begin
      if (summing) begin
        phase <= phase + 3'd1;
      end else begin
        busy <= 1'b0;
        done <= 1'b1;         // held until next build_start
      end
    end
  end

  // --------------------------------------------------
  // header words and checksum accumulator
  // --------------------------------------------------
  always_ff @(posedge tx_clock) begin
    if (build_start) begin
      hdr_word[0].len_word.ver_ihl      <= IP_VER_IHL;
      hdr_word[0].len_word.tos          <= IP_TOS;
      hdr_word[0].len_word.total_length <= 16'(IP_HDR_BYTES + UDP_HDR_BYTES) + payload_length;
      hdr_word[1].id_word.id            <= ident;
      hdr_word[1].id_word.flags         <= IP_FLAGS_DF;
      hdr_word[2].ttl_word.ttl          <= IP_TTL;
      hdr_word[2].ttl_word.protocol     <= IP_PROTO_UDP;
      hdr_word[2].ttl_word.checksum     <= 16'h0000; // zero while summing
      hdr_word[3].raw                   <= local_ip;
      hdr_word[4].raw                   <= destination_ip;
      csum_acc                          <= 20'd0;
    end else if (summing) begin
      csum_acc <= csum_acc + 20'(hdr_word[phase].half.hi) + 20'(hdr_word[phase].half.lo);
    end else if (busy) begin
      hdr_word[2].ttl_word.checksum <= ~fold_twice; // ones' complement of the sum
    end
  end

  assign ip_header = {hdr_word[0], hdr_word[1], hdr_word[2], hdr_word[3], hdr_word[4]};

  // done comes exactly seven cycles after the serializer's start pulse
  a_done_latency : assert property (@(posedge tx_clock) disable iff (reset)
    $rose(done) |-> $past(build_start, 7));

endmodule

//--- design/net_tx_pkg.sv
/* net_tx_pkg
   frame sizes, protocol field values and the ipv4 header word type
   shared by the udp transmit path */

package net_tx_pkg;

  // --------------------------------------------------
  // frame layout, in bytes
  // --------------------------------------------------
  localparam int MAC_HDR_BYTES   = 14;  // dst mac, src mac, ethertype
  localparam int IP_HDR_BYTES    = 20;  // no options
  localparam int UDP_HDR_BYTES   = 8;
  localparam int FRAME_HDR_BYTES = MAC_HDR_BYTES + IP_HDR_BYTES + UDP_HDR_BYTES;
  localparam int MAX_PAYLOAD     = 1472; // 1500 mtu less ip and udp headers

  localparam int IP_HDR_WORDS    = IP_HDR_BYTES / 4; // 32-bit words in the ip header

  // --------------------------------------------------
  // field values
  // --------------------------------------------------
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IP_VER_IHL     = 8'h45;   // v4, 5 words
  localparam logic [7:0]  IP_TOS         = 8'h00;
  localparam logic [7:0]  IP_TTL         = 8'd128;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
  localparam logic [15:0] IP_FLAGS_DF    = 16'h4000; // don't fragment, offset 0
  localparam logic [15:0] LOCAL_PORT     = 16'd1024;
  localparam logic [15:0] UDP_CHECKSUM   = 16'h0000; // checksum not computed

  // --------------------------------------------------
  // flow control
  // --------------------------------------------------
  localparam int CREDIT_MAX   = 8;
  localparam int CREDIT_WIDTH = $clog2(CREDIT_MAX + 1);

  // --------------------------------------------------
  // ipv4 header word
  // --------------------------------------------------
  // the header is built as named fields, then summed as 16-bit halves
  // by the checksum adder; both views overlay the same 32 bits
  typedef union packed {
    struct packed {
      logic [15:0] hi;           // first half on the wire
      logic [15:0] lo;
    } half;
    struct packed {
      logic [7:0]  ver_ihl;
      logic [7:0]  tos;
      logic [15:0] total_length; // ip + udp header + payload
    } len_word;
    struct packed {
      logic [15:0] id;
      logic [15:0] flags;        // flags and fragment offset
    } id_word;
    struct packed {
      logic [7:0]  ttl;
      logic [7:0]  protocol;
      logic [15:0] checksum;
    } ttl_word;
    logic [31:0] raw;            // address words
  } ip_word_t;

endpackage

//--- design/net_tx_top.sv
/* net_tx_top
   udp transmit path: request in, ethernet/ipv4/udp frame out one byte per cycle */

`timescale 1ns/1ps

module net_tx_top (
  input  logic        tx_clock,
  input  logic        reset,
  input  logic        udp_tx_request,
  input  logic [15:0] udp_tx_length,
  input  logic [7:0]  udp_tx_data,
  input  logic [47:0] local_mac,
  input  logic [47:0] destination_mac,
  input  logic [31:0] local_ip,
  input  logic [31:0] destination_ip,
  input  logic [15:0] destination_port,
  input  logic        tx_credit,
  output logic [7:0]  tx_data,
  output logic        tx_valid,
  output logic        udp_tx_enable,
  output logic        tx_active
);

  // --------------------------------------------------
  // serializer to builders
  // --------------------------------------------------
  logic         build_start;
  logic [15:0]  payload_length;
  logic [31:0]  captured_local_ip;
  logic [31:0]  captured_destination_ip;
  logic [15:0]  captured_destination_port;

  // builders back to serializer
  logic [159:0] ip_header;
  logic         ip_done;
  logic [63:0]  udp_header;
  logic         udp_done;

  ip_header_gen ip_header_gen_inst (
    .tx_clock       (tx_clock),
    .reset          (reset),
    .build_start    (build_start),
    .payload_length (payload_length),
    .local_ip       (captured_local_ip),
    .destination_ip (captured_destination_ip),
    .ip_header      (ip_header),
    .done           (ip_done)
  );

  udp_header_gen udp_header_gen_inst (
    .tx_clock         (tx_clock),
    .reset            (reset),
    .build_start      (build_start),
    .payload_length   (payload_length),
    .destination_port (captured_destination_port),
    .udp_header       (udp_header),
    .done             (udp_done)
  );

  frame_serializer frame_serializer_inst (
    .tx_clock                  (tx_clock),
    .reset                     (reset),
    .udp_tx_request            (udp_tx_request),
    .udp_tx_length             (udp_tx_length),
    .udp_tx_data               (udp_tx_data),
    .local_mac                 (local_mac),
    .destination_mac           (destination_mac),
    .local_ip                  (local_ip),
    .destination_ip            (destination_ip),
    .destination_port          (destination_port),
    .tx_credit                 (tx_credit),
    .ip_header                 (ip_header),
    .ip_done                   (ip_done),
    .udp_header                (udp_header),
    .udp_done                  (udp_done),
    .build_start               (build_start),
    .payload_length            (payload_length),
    .captured_local_ip         (captured_local_ip),
    .captured_destination_ip   (captured_destination_ip),
    .captured_destination_port (captured_destination_port),
    .tx_data                   (tx_data),
    .tx_valid                  (tx_valid),
    .udp_tx_enable             (udp_tx_enable),
    .tx_active                 (tx_active)
  );

endmodule

//--- design/udp_header_gen.sv
/* udp_header_gen
   registers the 8-byte udp header for each frame */

`timescale 1ns/1ps

module udp_header_gen
  import net_tx_pkg::*;
(
  input  logic        tx_clock,
  input  logic        reset,
  input  logic        build_start,      // one cycle pulse per frame
  input  logic [15:0] payload_length,
  input  logic [15:0] destination_port,
  output logic [63:0] udp_header,       // source port in the top bits
  output logic        done
);

  logic [15:0] udp_length;

  // udp length counts its own header
  assign udp_length = 16'(UDP_HDR_BYTES) + payload_length;

  // --------------------------------------------------
  // header register
  // --------------------------------------------------
  // layout on the wire:
  //   src port, dst port, length, checksum
  always_ff @(posedge tx_clock) begin
    if (build_start) begin
      udp_header <= {LOCAL_PORT,        // fixed source port
                     destination_port,
                     udp_length,
                     UDP_CHECKSUM};     // sent as zero
    end
  end

  // ready one cycle after start, held across the frame
  always_ff @(posedge tx_clock) begin
    if (reset) begin
      done <= 1'b0;
    end else if (build_start) begin
      done <= 1'b1;
    end
  end

  // serializer must never start a frame that cannot fit one mtu
  a_length_limit : assert property (@(posedge tx_clock) disable iff (reset)
    build_start |-> payload_length <= 16'(MAX_PAYLOAD));

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the udp transmit testbench with verilator, run it, check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module net_tx_tb \
  -Mdir "$BUILD_DIR" -o net_tx_sim

"./$BUILD_DIR/net_tx_sim" | tee "$LOG_FILE"

if grep -qx -- "=== PASS ===" "$LOG_FILE"; then
  echo "simulation passed"
else
  echo "simulation failed, see $LOG_FILE"
  exit 1
fi

//--- verification/net_tx_model.svh
/* net_tx_model
   random source and expected frame builder for the udp transmit testbench */

`ifndef NET_TX_MODEL_SVH
`define NET_TX_MODEL_SVH

  logic [31:0] lcg_state = 32'hb843_d75b;
  logic [7:0]  payload_bytes [64];    // payload of the frame in flight
  logic [7:0]  expected_frame [$];    // wire order, first byte at index 0

  // --------------------------------------------------
  // random numbers
  // --------------------------------------------------
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]}; // weak low bits moved up
  endfunction

  function automatic int unsigned random_below(input int unsigned limit);
    return next_random() % limit;
  endfunction

  // --------------------------------------------------
  // expected frame
  // --------------------------------------------------
  // high byte first, as on the wire
  function automatic void push_bytes(input logic [47:0] value, input int count);
    for (int i = count - 1; i >= 0; i--) expected_frame.push_back(value[8*i +: 8]);
  endfunction

  function automatic void build_expected_frame(
      input int          len,
      input int          frame_number,
      input logic [47:0] dmac,
      input logic [47:0] smac,
      input logic [31:0] sip,
      input logic [31:0] dip,
      input logic [15:0] dport);
    logic [15:0] halves [10];  // ip header as 16-bit halves
    logic [31:0] sum;
    halves = '{16'h4500, 16'(IP_HDR_BYTES + UDP_HDR_BYTES + len),
               16'(frame_number - 1), IP_FLAGS_DF, {IP_TTL, IP_PROTO_UDP}, 16'h0000,
               sip[31:16], sip[15:0], dip[31:16], dip[15:0]};
    sum = 32'd0;
    foreach (halves[i]) sum += 32'(halves[i]);
    // end-around carry until nothing is left above bit 15
    while (sum[31:16] != 16'd0) sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    halves[5] = ~sum[15:0];
    expected_frame.delete();
    push_bytes(dmac, 6);
    push_bytes(smac, 6);
    push_bytes(48'(ETHERTYPE_IPV4), 2);
    foreach (halves[i]) push_bytes(48'(halves[i]), 2);
    push_bytes(48'(LOCAL_PORT), 2);
    push_bytes(48'(dport), 2);
    push_bytes(48'(UDP_HDR_BYTES + len), 2);
    push_bytes(48'd0, 2);                  // udp checksum not used
    for (int i = 0; i < len; i++) expected_frame.push_back(payload_bytes[i]);
  endfunction

`endif

//--- verification/net_tx_tb.sv
/* net_tx_tb
   random udp frames under random credit flow, checked byte by byte
   against the frame model */

`timescale 1ns/1ps

module net_tx_tb
  import net_tx_pkg::*;
();

  localparam int FRAME_COUNT   = 30;
  localparam int START_TIMEOUT = 20;   // request to tx_active
  localparam int BYTE_TIMEOUT  = 200;  // longer than any credit drought
  localparam int END_TIMEOUT   = 4;

  logic        tx_clock;
  logic        reset;
  logic        udp_tx_request;
  logic [15:0] udp_tx_length;
  logic [7:0]  udp_tx_data;
  logic [47:0] local_mac;
  logic [47:0] destination_mac;
  logic [31:0] local_ip;
  logic [31:0] destination_ip;
  logic [15:0] destination_port;
  logic        tx_credit;
  logic [7:0]  tx_data;
  logic        tx_valid;
  logic        udp_tx_enable;
  logic        tx_active;

  logic        s_valid;                      // sampled at the falling edge
  logic        s_enable;
  logic        s_active;
  logic [7:0]  s_data;
  logic        next_request;                 // applied at the next drive point
  logic [15:0] next_length;
  logic        new_addresses;
  logic        full_rate;                    // one credit every cycle
  logic        timed_out;
  int          error_count;
  int          check_count;
  int          frames_done;
  int          credits;                      // mirror of the dut credit count
  int          granted_total;
  int          sent_total;
  int          drought;
  int          pidx;
  int          frame_len;

  `include "net_tx_model.svh"

  net_tx_top UUT (.*);

  always #2 tx_clock = ~tx_clock;

  task automatic report_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    $display("FAILED time %0t %s expected %0h actual %0h", $time, name, expected, actual);
    error_count++;
  endtask

  task automatic draw_addresses();
    logic [31:0] r [6];
    foreach (r[i]) r[i] = next_random();
    local_mac        = {r[0][15:0], r[1]};
    destination_mac  = {r[2][15:0], r[3]};
    local_ip         = r[4];
    destination_ip   = r[5];
    destination_port = r[0][31:16];
  endtask

  // --------------------------------------------------
  // one clock cycle
  // --------------------------------------------------
  task automatic step();
    logic pulse;
    @(posedge tx_clock);
    credits       += int'(tx_credit) - int'(s_valid);
    granted_total += int'(tx_credit);
    if (s_enable) pidx++;                 // source moves to the next payload byte
    #1;
    pulse = 1'b0;
    if (credits < CREDIT_MAX) begin       // never pulse at the ceiling
      if (drought > 0) drought--;
      else if (full_rate) pulse = 1'b1;
      else if (random_below(100) < 2) drought = 16 + int'(random_below(32));
      else pulse = random_below(100) < 40;
    end
    tx_credit      = pulse;
    udp_tx_request = next_request;
    udp_tx_length  = next_length;
    udp_tx_data    = (pidx < frame_len) ? payload_bytes[pidx] : 8'h00;
    if (new_addresses) begin
      draw_addresses();
      new_addresses = 1'b0;
    end
    @(negedge tx_clock);
    s_valid  = tx_valid;
    s_enable = udp_tx_enable;
    s_active = tx_active;
    s_data   = tx_data;
    if (s_valid) begin
      sent_total++;
      if (sent_total > granted_total) begin
        $display("%0t: byte sent without credit, %0d sent against %0d granted",
                 $time, sent_total, granted_total);
        error_count++;
      end
    end
    if (s_enable && !s_valid) report_value("udp_tx_enable", 64'd0, 64'd1);
  endtask

  // --------------------------------------------------
  // one frame, request to tx_active low
  // --------------------------------------------------
  task automatic run_frame(input int frame_number);
    int          len;
    int          idx;
    int          wait_count;
    logic [31:0] r;
    len = 1 + int'(random_below(40));
    for (int i = 0; i < len; i++) begin
      r = next_random();
      payload_bytes[i] = r[7:0];
    end
    build_expected_frame(len, frame_number, destination_mac, local_mac, local_ip,
                         destination_ip, destination_port);
    full_rate = random_below(3) == 0;
    if (!full_rate && random_below(3) == 0) drought = 40 + int'(random_below(40));
    pidx         = 0;
    frame_len    = len;
    next_request = 1'b1;
    next_length  = 16'(len);
    wait_count   = 0;
    step();
    while (!s_active && wait_count < START_TIMEOUT) begin
      step();
      wait_count++;
    end
    if (!s_active) begin
      $display("%0t: timeout, tx_active never rose for frame %0d", $time, frame_number);
      error_count++;
      timed_out = 1'b1;
      return;
    end
    next_request  = 1'b0;
    new_addresses = 1'b1;                 // in flight, belongs to the next frame
    idx        = 0;
    wait_count = 0;
    while (idx < expected_frame.size() && !timed_out) begin
      if (s_valid) begin
        check_count++;
        if (s_data !== expected_frame[idx])
          report_value($sformatf("tx_data[%0d]", idx), 64'(expected_frame[idx]), 64'(s_data));
        if (s_enable !== (idx >= FRAME_HDR_BYTES))
          report_value($sformatf("udp_tx_enable[%0d]", idx), 64'(idx >= FRAME_HDR_BYTES),
                       64'(s_enable));
        idx++;
        wait_count = 0;
      end else if (wait_count == BYTE_TIMEOUT) begin
        $display("%0t: timeout waiting for byte %0d of frame %0d", $time, idx, frame_number);
        error_count++;
        timed_out = 1'b1;
      end else begin
        wait_count++;
      end
      if (!timed_out) step();
    end
    // tx_active drops on the edge after the last byte
    wait_count = 0;
    while (s_active && !timed_out) begin
      if (wait_count == 0) report_value("tx_active", 64'd0, 64'd1);
      if (s_valid) begin
        $display("%0t: extra byte after the end of frame %0d", $time, frame_number);
        error_count++;
      end
      if (wait_count == END_TIMEOUT) begin
        $display("%0t: timeout, tx_active stuck high after frame %0d", $time, frame_number);
        error_count++;
        timed_out = 1'b1;
      end else begin
        wait_count++;
        step();
      end
    end
    frames_done++;
  endtask

  initial begin
    tx_clock         = 1'b0;
    reset            = 1'b1;
    udp_tx_request   = 1'b0;
    udp_tx_length    = 16'd0;
    udp_tx_data      = 8'h00;
    local_mac        = 48'd0;
    destination_mac  = 48'd0;
    local_ip         = 32'd0;
    destination_ip   = 32'd0;
    destination_port = 16'd0;
    tx_credit        = 1'b0;
    s_valid          = 1'b0;
    s_enable         = 1'b0;
    s_active         = 1'b0;
    s_data           = 8'h00;
    next_request     = 1'b0;
    next_length      = 16'd0;
    full_rate        = 1'b0;
    timed_out        = 1'b0;
    new_addresses    = 1'b1;              // first frame addresses
    error_count      = 0;
    check_count      = 0;
    frames_done      = 0;
    credits          = 0;
    granted_total    = 0;
    sent_total       = 0;
    drought          = 0;
    pidx             = 0;
    frame_len        = 0;
    repeat (3) @(posedge tx_clock);
    #1;
    reset = 1'b0;
    // idle, no request yet
    for (int i = 0; i < 10; i++) begin
      step();
      check_count++;
      if (s_valid) report_value("tx_valid", 64'd0, 64'd1);
      if (s_enable) report_value("udp_tx_enable", 64'd0, 64'd1);
      if (s_active) report_value("tx_active", 64'd0, 64'd1);
    end
    for (int f = 1; f <= FRAME_COUNT && !timed_out; f++) run_frame(f);
    $display("frames %0d, bytes %0d, checks %0d, errors %0d",
             frames_done, sent_total, check_count, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
